// ==== bench/run_table.svh ====
/* Run table for the serial read engine testbench, included inside the testbench module.
   Each row gives one run with its address config, index range, pattern flags and request count. */

`ifndef RUN_TABLE_SVH
`define RUN_TABLE_SVH

typedef struct packed {
    serial_read_pkg::addr_t  base;
    serial_read_pkg::index_t first;
    serial_read_pkg::index_t last;
    serial_read_pkg::index_t stride;
    logic                    shift_left;
    serial_read_pkg::shift_t shift_amount;
    // Sparse random pops and pause toggling
    logic                    busy;
    // Keep start and config_valid high after the run
    logic                    hold;
    // Number of requests the run must produce
    int                      count;
} run_row_t;

localparam int NUM_RUNS = 7;

run_row_t run_table [NUM_RUNS];

task automatic fill_run_table();
    // base, first, last, stride, shift_left, shift_amount, busy, hold, count
    run_table[0] = '{64'h0000_0000_1000_0000, 32'd0, 32'd24, 32'd1, 1'b1, 6'd3, 1'b0, 1'b0, 24};
    run_table[1] = '{64'hffff_8000_0000_0000, 32'd100, 32'd180, 32'd4, 1'b0, 6'd2, 1'b0, 1'b0, 20};
    run_table[2] = '{64'h0000_0000_0000_4000, 32'd50, 32'd50, 32'd1, 1'b1, 6'd2, 1'b0, 1'b0, 0};
    run_table[3] = '{64'h0000_0000_0000_8000, 32'd90, 32'd10, 32'd2, 1'b0, 6'd1, 1'b0, 1'b0, 0};
    run_table[4] = '{64'h0000_0000_0000_2000, 32'd7, 32'd407, 32'd2, 1'b1, 6'd6, 1'b1, 1'b0, 200};
    run_table[5] = '{64'h0000_0000_8000_0000, 32'd0, 32'd300, 32'd3, 1'b0, 6'd1, 1'b1, 1'b0, 100};
    // Shift past the index width
    run_table[6] = '{64'h0000_0040_0000_0000, 32'd11, 32'd61, 32'd5, 1'b1, 6'd32, 1'b0, 1'b1, 10};
endtask

`endif

// ==== bench/serial_read_engine_tb.sv ====
/* Testbench for the serial read engine. Runs every row of run_table.svh and checks each
   request, ready and done against a reference list built from the run config. */

`timescale 1ns/1ps
`default_nettype none

module serial_read_engine_tb;

    localparam int RUN_TIMEOUT  = 20000;
    localparam int IDLE_TIMEOUT = 50;

    logic                    ap_clk;
    logic                    areset_engine;
    logic                    config_valid;
    logic                    start;
    logic                    pause;
    serial_read_pkg::addr_t  array_pointer;
    serial_read_pkg::index_t start_read;
    serial_read_pkg::index_t end_read;
    serial_read_pkg::index_t stride;
    logic                    shift_left;
    serial_read_pkg::shift_t shift_amount;
    logic                    request_pop;
    logic                    ready;
    logic                    done;
    logic                    request_valid;
    serial_read_pkg::addr_t  request_address;
    serial_read_pkg::index_t request_index;

    integer                  seed;
    serial_read_pkg::addr_t  exp_address [$];
    serial_read_pkg::index_t exp_index [$];

    `include "run_table.svh"

    serial_read_engine serial_read_engine_inst (
        .ap_clk         (ap_clk),
        .areset_engine  (areset_engine),
        .config_valid   (config_valid),
        .start          (start),
        .pause          (pause),
        .array_pointer  (array_pointer),
        .start_read     (start_read),
        .end_read       (end_read),
        .stride         (stride),
        .shift_left     (shift_left),
        .shift_amount   (shift_amount),
        .request_pop    (request_pop),
        .ready          (ready),
        .done           (done),
        .request_valid  (request_valid),
        .request_address(request_address),
        .request_index  (request_index)
    );

    always #2 ap_clk = ~ap_clk;

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic stop_with_failure();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_request(input serial_read_pkg::addr_t got_address,
                                 input serial_read_pkg::index_t got_index,
                                 input serial_read_pkg::addr_t want_address,
                                 input serial_read_pkg::index_t want_index,
                                 input int run);
        if (got_address !== want_address || got_index !== want_index) begin
            $display("FAIL @%0t: run %0d request addr %h index %0d, expected addr %h index %0d",
                     $time, run, got_address, got_index, want_address, want_index);
            stop_with_failure();
        end
    endtask

    task automatic check_level(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("FAIL @%0t: %s is %b, expected %b", $time, what, got, want);
            stop_with_failure();
        end
    endtask

    // Reference list of indices from first while below last, each with its shifted address
    task automatic build_expected(input run_row_t row);
        longint                 idx;
        serial_read_pkg::addr_t wide;
        exp_address.delete();
        exp_index.delete();
        idx = longint'(row.first);
        while (idx < longint'(row.last)) begin
            wide = serial_read_pkg::addr_t'(idx);
            if (row.shift_left) begin
                wide = wide << row.shift_amount;
            end else begin
                wide = wide >> row.shift_amount;
            end
            exp_address.push_back(row.base + wide);
            exp_index.push_back(serial_read_pkg::index_t'(idx));
            idx = idx + longint'(row.stride);
        end
    endtask

    // ------------------------------
    // Waits and run sequencing
    // ------------------------------
    task automatic wait_for_ready(input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge ap_clk);
            cycles++;
            check_level(request_valid, 1'b0, "request_valid with no request left");
            if (cycles > IDLE_TIMEOUT) begin
                $display("Timeout: ready did not rise %s within %0d cycles", what, IDLE_TIMEOUT);
                stop_with_failure();
            end
        end while (!ready);
    endtask

    // Pops an empty queue and expects no valid
    task automatic check_queue_empty();
        repeat (4) begin
            @(posedge ap_clk);
            request_pop <= 1'b1;
            pause       <= 1'b0;
            @(negedge ap_clk);
            check_level(request_valid, 1'b0, "request_valid on empty queue");
        end
        @(posedge ap_clk);
        request_pop <= 1'b0;
        @(negedge ap_clk);
        check_level(request_valid, 1'b0, "request_valid on empty queue");
    endtask

    task automatic run_one(input int num);
        run_row_t row;
        int       cycles;
        int       got;
        logic     accepted;
        row = run_table[num];
        build_expected(row);
        if (exp_index.size() != row.count) begin
            $display("Run %0d: reference list has %0d requests but the table lists %0d",
                     num, exp_index.size(), row.count);
            stop_with_failure();
        end
        @(posedge ap_clk);
        array_pointer <= row.base;
        start_read    <= row.first;
        end_read      <= row.last;
        stride        <= row.stride;
        shift_left    <= row.shift_left;
        shift_amount  <= row.shift_amount;
        config_valid  <= 1'b1;
        start         <= 1'b1;
        cycles   = 0;
        got      = 0;
        accepted = 1'b0;
        while (!(accepted && done && got == exp_index.size())) begin
            @(posedge ap_clk);
            if (accepted && !row.hold) begin
                start        <= 1'b0;
                config_valid <= 1'b0;
            end
            if (row.busy) begin
                request_pop <= (($random(seed) & 3) == 0);
                pause       <= ((cycles % 40) >= 25);
            end else begin
                request_pop <= 1'b1;
                pause       <= 1'b0;
            end
            @(negedge ap_clk);
            cycles++;
            if (!ready && !accepted) begin
                check_level(done, 1'b0, "done at run start");
                accepted = 1'b1;
            end
            if (accepted && !done) check_level(ready, 1'b0, "ready during run");
            if (request_valid) begin
                if (got >= exp_index.size()) begin
                    $display("FAIL @%0t: run %0d extra request index %0d",
                             $time, num, request_index);
                    stop_with_failure();
                end
                check_request(request_address, request_index, exp_address[got],
                              exp_index[got], num);
                got++;
            end
            if (cycles > RUN_TIMEOUT) begin
                $display("Timeout: run %0d did not finish within %0d cycles, %0d of %0d seen",
                         num, RUN_TIMEOUT, got, exp_index.size());
                stop_with_failure();
            end
        end
        // Held start keeps the engine in its done state
        if (row.hold) begin
            repeat (8) begin
                @(posedge ap_clk);
                request_pop <= 1'b0;
                pause       <= 1'b0;
                @(negedge ap_clk);
                check_level(ready, 1'b0, "ready with start held");
                check_level(done, 1'b1, "done with start held");
                check_level(request_valid, 1'b0, "request_valid with start held");
            end
            @(posedge ap_clk);
            start        <= 1'b0;
            config_valid <= 1'b0;
        end
        wait_for_ready("after a run");
        check_level(done, 1'b1, "done when idle");
        check_queue_empty();
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        seed          = 32'h57ee_6eb8;
        ap_clk        = 1'b0;
        areset_engine = 1'b1;
        config_valid  = 1'b0;
        start         = 1'b0;
        pause         = 1'b0;
        array_pointer = '0;
        start_read    = '0;
        end_read      = '0;
        stride        = '0;
        shift_left    = 1'b0;
        shift_amount  = '0;
        request_pop   = 1'b0;
        fill_run_table();
        for (int c = 0; c < 5; c++) begin
            @(posedge ap_clk);
            if (c == 4) areset_engine <= 1'b0;
            @(negedge ap_clk);
            check_level(ready, 1'b0, "ready in reset");
            check_level(done, 1'b0, "done in reset");
            check_level(request_valid, 1'b0, "request_valid in reset");
        end
        wait_for_ready("after reset");
        check_level(done, 1'b1, "done after reset");
        check_level(request_valid, 1'b0, "request_valid after reset");
        check_queue_empty();
        for (int r = 0; r < NUM_RUNS; r++) begin
            run_one(r);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule : serial_read_engine_tb

`default_nettype wire

// ==== hdl/index_step_if.sv ====
/* Counter control between the run sequencer and the request generator.
   The sequencer loads and steps the counter, the generator returns the current index. */

`timescale 1ns/1ps
`default_nettype none

interface index_step_if #(
    parameter int INDEX_WIDTH = serial_read_pkg::INDEX_WIDTH
);

    // One-cycle pulse, counter takes start_value on the next edge
    logic                   load;
    // Level, one request per cycle while high
    logic                   step;
    logic [INDEX_WIDTH-1:0] start_value;
    logic [INDEX_WIDTH-1:0] stride_value;
    // Current counter value
    logic [INDEX_WIDTH-1:0] index;

    modport seq (
        output load, step, start_value, stride_value,
        input  index
    );

    modport gen (
        input  load, step, start_value, stride_value,
        output index
    );

endinterface : index_step_if

`default_nettype wire

// ==== hdl/request_fifo.sv ====
/* Synchronous request queue with a programmable-full level.
   A pop returns the head entry with valid one cycle later; pops on empty are dropped. */

`timescale 1ns/1ps
`default_nettype none

module request_fifo #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8,
    parameter int INDEX_WIDTH = serial_read_pkg::INDEX_WIDTH
) (
    input  wire logic                    ap_clk,
    input  wire logic                    areset_engine,
    input  wire logic                    push,
    input  wire serial_read_pkg::addr_t  push_address,
    input  wire serial_read_pkg::index_t push_index,
    input  wire logic                    pop,
    output logic                         prog_full,
    output logic                         valid,
    output serial_read_pkg::addr_t       pop_address,
    output serial_read_pkg::index_t      pop_index
);

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    serial_read_pkg::addr_t mem_address [FIFO_DEPTH];
    logic [INDEX_WIDTH-1:0] mem_index   [FIFO_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 do_push;
    logic                 do_pop;

    assign do_push   = push && (count != CNT_WIDTH'(FIFO_DEPTH));
    assign do_pop    = pop && (count != '0);
    assign prog_full = (count >= CNT_WIDTH'(PROG_THRESH));

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            valid <= do_pop;
        end
    end

    // Storage and output word
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem_address[wr_ptr] <= push_address;
            mem_index[wr_ptr]   <= push_index;
        end
        if (do_pop) begin
            pop_address <= mem_address[rd_ptr];
            pop_index   <= mem_index[rd_ptr];
        end
    end

endmodule : request_fifo

`default_nettype wire

// ==== hdl/request_generator.sv ====
/* Index counter and request address computation.
   Each step registers one request word for the request FIFO. */

`timescale 1ns/1ps
`default_nettype none

module request_generator #(
    parameter int INDEX_WIDTH = serial_read_pkg::INDEX_WIDTH
) (
    input  wire logic                    ap_clk,
    input  wire logic                    areset_engine,
    input  wire serial_read_pkg::addr_t  array_pointer,
    input  wire logic                    shift_left,
    input  wire serial_read_pkg::shift_t shift_amount,
    index_step_if.gen                    steps,
    output logic                         push,
    output serial_read_pkg::addr_t       push_address,
    output serial_read_pkg::index_t      push_index
);

    logic [INDEX_WIDTH-1:0]  index;
    serial_read_pkg::addr_t  index_wide;
    serial_read_pkg::addr_t  offset;

    // ------------------------------
    // Index counter
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (steps.load) begin
            index <= steps.start_value;
        end else if (steps.step) begin
            index <= index + steps.stride_value;
        end
    end

    assign steps.index = index;

    // Zero-extend before shifting so left shifts keep the upper bits
    assign index_wide = {{(serial_read_pkg::ADDR_WIDTH - INDEX_WIDTH){1'b0}}, index};
    assign offset     = shift_left ? (index_wide << shift_amount)
                                   : (index_wide >> shift_amount);

    // ------------------------------
    // Request register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            push <= 1'b0;
        end else begin
            push <= steps.step;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (steps.step) begin
            push_address <= array_pointer + offset;
            push_index   <= index;
        end
    end

endmodule : request_generator

`default_nettype wire

// ==== hdl/serial_read_engine.sv ====
/* Top level of the serial read engine: sequencer, request generator and request FIFO.
   Holds the base pointer and shift config for the duration of a run. */

`timescale 1ns/1ps
`default_nettype none

module serial_read_engine #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8,
    parameter int INDEX_WIDTH = serial_read_pkg::INDEX_WIDTH
) (
    input  wire logic                    ap_clk,
    input  wire logic                    areset_engine,
    input  wire logic                    config_valid,
    input  wire logic                    start,
    input  wire logic                    pause,
    input  wire serial_read_pkg::addr_t  array_pointer,
    input  wire serial_read_pkg::index_t start_read,
    input  wire serial_read_pkg::index_t end_read,
    input  wire serial_read_pkg::index_t stride,
    input  wire logic                    shift_left,
    input  wire serial_read_pkg::shift_t shift_amount,
    input  wire logic                    request_pop,
    output logic                         ready,
    output logic                         done,
    output logic                         request_valid,
    output serial_read_pkg::addr_t       request_address,
    output serial_read_pkg::index_t      request_index
);

    serial_read_pkg::addr_t  array_pointer_q;
    logic                    shift_left_q;
    serial_read_pkg::shift_t shift_amount_q;

    logic                    push;
    serial_read_pkg::addr_t  push_address;
    serial_read_pkg::index_t push_index;
    logic                    prog_full;

    index_step_if #(.INDEX_WIDTH(INDEX_WIDTH)) steps ();

    // Address config, taken on the same edge the sequencer leaves idle
    always_ff @(posedge ap_clk) begin
        if (ready && config_valid && start) begin
            array_pointer_q <= array_pointer;
            shift_left_q    <= shift_left;
            shift_amount_q  <= shift_amount;
        end
    end

    // ------------------------------
    // Blocks
    // ------------------------------
    serial_read_sequencer #(.INDEX_WIDTH(INDEX_WIDTH)) sequencer_inst (
        .ap_clk       (ap_clk),
        .areset_engine(areset_engine),
        .config_valid (config_valid),
        .start        (start),
        .pause        (pause),
        .start_read   (start_read),
        .end_read     (end_read),
        .stride       (stride),
        .prog_full    (prog_full),
        .steps        (steps.seq),
        .ready        (ready),
        .done         (done)
    );

    request_generator #(.INDEX_WIDTH(INDEX_WIDTH)) generator_inst (
        .ap_clk       (ap_clk),
        .areset_engine(areset_engine),
        .array_pointer(array_pointer_q),
        .shift_left   (shift_left_q),
        .shift_amount (shift_amount_q),
        .steps        (steps.gen),
        .push         (push),
        .push_address (push_address),
        .push_index   (push_index)
    );

    request_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH),
        .INDEX_WIDTH(INDEX_WIDTH)
    ) fifo_inst (
        .ap_clk       (ap_clk),
        .areset_engine(areset_engine),
        .push         (push),
        .push_address (push_address),
        .push_index   (push_index),
        .pop          (request_pop),
        .prog_full    (prog_full),
        .valid        (request_valid),
        .pop_address  (request_address),
        .pop_index    (request_index)
    );

endmodule : serial_read_engine

`default_nettype wire

// ==== hdl/serial_read_pkg.sv ====
/* Shared widths, vector types and the run state encoding for the serial read engine.
   RTL files refer to these by scoped names. */

`default_nettype none

package serial_read_pkg;

    // ------------------------------
    // Widths
    // ------------------------------

    // Index, start, end and stride values
    parameter int INDEX_WIDTH = 32;

    // Base pointer and request address
    parameter int ADDR_WIDTH = 64;

    // Shift amount applied to the index
    parameter int SHIFT_WIDTH = 6;

    // ------------------------------
    // Vector types
    // ------------------------------

    typedef logic [INDEX_WIDTH-1:0] index_t;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    typedef logic [SHIFT_WIDTH-1:0] shift_t;

    // ------------------------------
    // Run sequencer states
    // ------------------------------

    typedef enum logic [2:0] {
        RUN_RESET,
        RUN_IDLE,
        RUN_SETUP,
        RUN_BUSY,
        RUN_PAUSE,
        RUN_DONE
    } run_state_t;

endpackage : serial_read_pkg

`default_nettype wire

// ==== hdl/serial_read_sequencer.sv ====
/* Run control for the serial read engine: config capture, end test, pause handling.
   Drives the counter through index_step_if and reports ready and done. */

`timescale 1ns/1ps
`default_nettype none

module serial_read_sequencer #(
    parameter int INDEX_WIDTH = serial_read_pkg::INDEX_WIDTH
) (
    input  wire logic                    ap_clk,
    input  wire logic                    areset_engine,
    input  wire logic                    config_valid,
    input  wire logic                    start,
    input  wire logic                    pause,
    input  wire serial_read_pkg::index_t start_read,
    input  wire serial_read_pkg::index_t end_read,
    input  wire serial_read_pkg::index_t stride,
    input  wire logic                    prog_full,
    index_step_if.seq                    steps,
    output logic                         ready,
    output logic                         done
);

    serial_read_pkg::run_state_t state;
    serial_read_pkg::run_state_t next_state;

    logic                   start_q;
    logic                   pause_q;
    logic [INDEX_WIDTH-1:0] start_read_q;
    logic [INDEX_WIDTH-1:0] end_read_q;
    logic [INDEX_WIDTH-1:0] stride_q;
    logic                   below_end;

    // ------------------------------
    // Input registers
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            start_q <= 1'b0;
            pause_q <= 1'b0;
        end else begin
            start_q <= start;
            pause_q <= pause;
        end
    end

    // Run config, held from RUN_SETUP until the next run
    always_ff @(posedge ap_clk) begin
        if (state == serial_read_pkg::RUN_IDLE && config_valid && start) begin
            start_read_q <= start_read;
            end_read_q   <= end_read;
            stride_q     <= stride;
        end
    end

    assign below_end = steps.index < end_read_q;

    // ------------------------------
    // State machine
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state <= serial_read_pkg::RUN_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            serial_read_pkg::RUN_RESET: next_state = serial_read_pkg::RUN_IDLE;
            serial_read_pkg::RUN_IDLE: begin
                if (config_valid && start) next_state = serial_read_pkg::RUN_SETUP;
            end
            serial_read_pkg::RUN_SETUP: next_state = serial_read_pkg::RUN_BUSY;
            serial_read_pkg::RUN_BUSY: begin
                if (!below_end) begin
                    next_state = serial_read_pkg::RUN_DONE;
                end else if (prog_full || pause_q) begin
                    next_state = serial_read_pkg::RUN_PAUSE;
                end
            end
            serial_read_pkg::RUN_PAUSE: begin
                if (!prog_full && !pause_q) next_state = serial_read_pkg::RUN_BUSY;
            end
            serial_read_pkg::RUN_DONE: begin
                // Stay done while the host still holds the run request
                if (!(config_valid && start_q)) next_state = serial_read_pkg::RUN_IDLE;
            end
            default: next_state = serial_read_pkg::RUN_RESET;
        endcase
    end

    // Counter control
    assign steps.load         = (state == serial_read_pkg::RUN_SETUP);
    assign steps.step         = (state == serial_read_pkg::RUN_BUSY) && below_end;
    assign steps.start_value  = start_read_q;
    assign steps.stride_value = stride_q;

    // Status levels, registered from the next state
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            ready <= 1'b0;
            done  <= 1'b0;
        end else begin
            ready <= (next_state == serial_read_pkg::RUN_IDLE);
            done  <= (next_state == serial_read_pkg::RUN_IDLE) ||
                     (next_state == serial_read_pkg::RUN_DONE);
        end
    end

endmodule : serial_read_sequencer

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the serial read engine testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f \
    --top-module serial_read_engine_tb -Mdir obj_dir -o serial_read_engine_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/serial_read_engine_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0

// ==== sources.f ====
+incdir+bench
hdl/serial_read_pkg.sv
hdl/index_step_if.sv
hdl/serial_read_sequencer.sv
hdl/request_generator.sv
hdl/request_fifo.sv
hdl/serial_read_engine.sv
bench/serial_read_engine_tb.sv
